/* source/neuron_pkg.sv */
package neuron_pkg;

    // Sizing
    // --------------------
    // Fractional bits of v and u
    localparam int MODEL_PREC  = 10;
    localparam int STATE_BW    = MODEL_PREC + 8;
    // Currents and weights carry WEIGHT_PREC fractional bits
    localparam int CURRENT_BW  = 9;
    localparam int WEIGHT_BW   = 7;
    localparam int WEIGHT_PREC = 2;
    localparam int TABLE_ROWS  = 20;
    localparam int ROW_BW      = $clog2(TABLE_ROWS);
    localparam int INDEX_BW    = 8;
    localparam int CFG_ADDR_BW = 6;
    localparam int CFG_DATA_BW = 18;
    localparam int STEP_BW     = 6;
    localparam int STEP_RESET  = 40;
    localparam int OUT_BUS_BW  = 8;

    // Izhikevich datapath widths
    // --------------------
    // Bias plus synaptic current, one guard bit
    localparam int SUM_BW    = CURRENT_BW + 1;
    // v with half the fraction dropped, input to the squarer
    localparam int SQ_IN_BW  = MODEL_PREC / 2 + 8;
    // Square truncated to 25 bits
    localparam int V_SQ_BW   = 25;
    localparam int V_POLY_BW = MODEL_PREC + 11;
    localparam int DRIVE_BW  = CURRENT_BW + 1 + MODEL_PREC;
    localparam int DV_BW     = MODEL_PREC + 13;
    // b*v - u and a*(b*v - u)
    localparam int BV_BW     = MODEL_PREC + 9;
    localparam int DU_BW     = MODEL_PREC + 2;

    // Model constants, integer part only
    // --------------------
    localparam int V_RESET       = -70;
    localparam int U_RESET       = -20;
    localparam int V_SPIKE       = 30;
    localparam int V_AFTER_SPIKE = -65;
    localparam int U_SPIKE_STEP  = 6;
    localparam int BIAS_140      = 140;

    // Reset values in fixed point
    localparam logic signed [STATE_BW-1:0] V_RESET_FX = STATE_BW'(V_RESET * (1 << MODEL_PREC));
    localparam logic signed [STATE_BW-1:0] U_RESET_FX = STATE_BW'(U_RESET * (1 << MODEL_PREC));

    // Configuration address map
    // --------------------
    localparam int CFG_BIAS_ADDR  = 0;
    localparam int CFG_STEP_ADDR  = 1;
    // Rows start here, index word then weight word
    localparam int CFG_TABLE_BASE = 2;
    localparam int CFG_WORDS      = CFG_TABLE_BASE + 2 * TABLE_ROWS;

    // Kind of configuration write
    typedef enum logic [2:0] {
        CFG_BIAS,
        CFG_STEP,
        CFG_INDEX,
        CFG_WEIGHT,
        CFG_NONE
    } cfg_kind_e;

    typedef struct packed {
        logic                   we;
        logic [CFG_ADDR_BW-1:0] addr;
        logic [CFG_DATA_BW-1:0] data;
    } cfg_write_t;

    typedef struct packed {
        logic                vld;
        logic [INDEX_BW-1:0] index;
    } axon_in_t;

    typedef struct packed {
        logic signed [STATE_BW-1:0] v;
        logic signed [STATE_BW-1:0] u;
    } neuron_state_t;

endpackage

/* source/synapse_decode.sv */
`timescale 1ns/10ps

module synapse_decode import neuron_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         nc_reset,
    input  logic                         nc_evaluate,
    input  cfg_write_t                   cfg,
    input  axon_in_t                     axon,
    output logic signed [CURRENT_BW-1:0] syn_current,
    output logic signed [CURRENT_BW-1:0] bias_current
);

    // Write decode
    cfg_kind_e              cfg_kind;
    logic [CFG_ADDR_BW-1:0] cfg_offset;
    logic [ROW_BW-1:0]      cfg_row;

    // Synapse table, one index and one weight per row
    logic [INDEX_BW-1:0]         table_i [TABLE_ROWS];
    logic signed [WEIGHT_BW-1:0] table_w [TABLE_ROWS];
    // Status bit per row, set means next match subtracts
    logic [TABLE_ROWS-1:0]       table_s;

    // Registered axon input, cuts fan-out into the row compare
    axon_in_t                     axon_q;
    logic [TABLE_ROWS-1:0]        row_match;
    logic signed [CURRENT_BW-1:0] syn_nxt;

    // Configuration decode
    // --------------------
    always_comb begin
        // Offset into the table region, row is half of it
        cfg_offset = cfg.addr - CFG_ADDR_BW'(CFG_TABLE_BASE);
        cfg_row    = ROW_BW'(cfg_offset >> 1);
        if (!cfg.we) begin
            cfg_kind = CFG_NONE;
        end else if (cfg.addr == CFG_ADDR_BW'(CFG_BIAS_ADDR)) begin
            cfg_kind = CFG_BIAS;
        end else if (cfg.addr == CFG_ADDR_BW'(CFG_STEP_ADDR)) begin
            // Step length lives in the result stage
            cfg_kind = CFG_STEP;
        end else if (cfg.addr < CFG_ADDR_BW'(CFG_WORDS)) begin
            // Even offset is the index word, odd is the weight
            cfg_kind = cfg_offset[0] ? CFG_WEIGHT : CFG_INDEX;
        end else begin
            // Past the last row
            cfg_kind = CFG_NONE;
        end
    end

    // Constant bias current
    always_ff @(posedge clk) begin
        if (rst) begin
            bias_current <= '0;
        end else if (cfg_kind == CFG_BIAS) begin
            bias_current <= CURRENT_BW'(cfg.data);
        end
    end

    // Table rows, untouched by nc_reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < TABLE_ROWS; r++) begin
                table_i[r] <= '0;
                table_w[r] <= '0;
            end
        end else if (cfg_kind == CFG_INDEX) begin
            table_i[cfg_row] <= INDEX_BW'(cfg.data);
        end else if (cfg_kind == CFG_WEIGHT) begin
            table_w[cfg_row] <= WEIGHT_BW'(cfg.data);
        end
    end

    // Index match and accumulate
    // --------------------
    always_comb begin
        // Every row compares against the registered index at once
        for (int r = 0; r < TABLE_ROWS; r++) begin
            row_match[r] = axon_q.vld && (axon_q.index == table_i[r]);
        end
    end

    always_comb begin
        syn_nxt = syn_current;
        // Signed sum of all matched weights
        for (int r = 0; r < TABLE_ROWS; r++) begin
            if (row_match[r]) begin
                if (table_s[r]) begin
                    syn_nxt = syn_nxt - CURRENT_BW'(table_w[r]);
                end else begin
                    syn_nxt = syn_nxt + CURRENT_BW'(table_w[r]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || nc_reset) begin
            axon_q      <= '0;
            syn_current <= '0;
            table_s     <= '0;
        end else begin
            axon_q.vld <= axon.vld;
            // Index only loads with a valid beat
            if (axon.vld) begin
                axon_q.index <= axon.index;
            end
            // Current only moves on a lookup or an evaluate
            if (nc_evaluate || axon_q.vld) begin
                syn_current <= syn_nxt;
            end
            // Matched rows flip between add and subtract
            if (axon_q.vld) begin
                table_s <= table_s ^ row_match;
            end
        end
    end

endmodule

/* source/izh_execute.sv */
`timescale 1ns/10ps

module izh_execute import neuron_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         nc_reset,
    input  logic                         nc_evaluate,
    input  logic signed [CURRENT_BW-1:0] syn_current,
    input  logic signed [CURRENT_BW-1:0] bias_current,
    output logic                         spiking,
    output neuron_state_t                state
);

    // Model state
    logic signed [STATE_BW-1:0]  v;
    logic signed [STATE_BW-1:0]  u;
    logic signed [STATE_BW-1:0]  v_nxt;
    logic signed [STATE_BW-1:0]  u_nxt;

    // v update terms
    logic signed [SQ_IN_BW-1:0]  v_half;
    logic signed [V_SQ_BW-1:0]   v_sq;
    logic signed [V_POLY_BW-1:0] v_sq_k;
    logic signed [V_POLY_BW-1:0] v_x5;
    logic signed [SUM_BW-1:0]    i_sum;
    logic signed [DRIVE_BW-1:0]  drive;
    logic signed [DV_BW-1:0]     dv;
    logic signed [V_POLY_BW-1:0] v_raw;

    // u update terms
    logic signed [BV_BW-1:0]     bv_mu;
    logic signed [DU_BW-1:0]     du;
    logic signed [STATE_BW-1:0]  u_raw;

    // State registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst || nc_reset) begin
            v <= V_RESET_FX;
            u <= U_RESET_FX;
        end else if (nc_evaluate) begin
            v <= v_nxt;
            u <= u_nxt;
        end
    end

    // Next v
    // --------------------
    always_comb begin
        // Drop half the fraction so the square stays in range
        v_half = SQ_IN_BW'(v >>> (MODEL_PREC / 2));
        // Extend before multiplying, keep the low 25 bits
        v_sq   = V_SQ_BW'(v_half) * V_SQ_BW'(v_half);
        // About 0.04 v^2
        v_sq_k = V_POLY_BW'((v_sq >>> 5) + (v_sq >>> 7) + (v_sq >>> 10));
        v_x5   = (V_POLY_BW'(v) <<< 2) + V_POLY_BW'(v);

        // Drive term, 140 plus input current aligned to the model fraction
        i_sum  = SUM_BW'(bias_current) + SUM_BW'(syn_current);
        drive  = DRIVE_BW'(BIAS_140 * (1 << MODEL_PREC))
               + (DRIVE_BW'(i_sum) <<< (MODEL_PREC - WEIGHT_PREC));

        dv     = DV_BW'(v_sq_k) + DV_BW'(v_x5) - DV_BW'(u) + DV_BW'(drive);
        // Quarter time step
        v_raw  = V_POLY_BW'(v) + V_POLY_BW'(dv >>> 2);

        // Threshold on the integer part, only in an evaluate cycle
        spiking = nc_evaluate && ((v_raw >>> MODEL_PREC) > V_POLY_BW'(V_SPIKE));
        v_nxt   = spiking ? STATE_BW'(V_AFTER_SPIKE * (1 << MODEL_PREC)) : STATE_BW'(v_raw);
    end

    // Next u
    // --------------------
    always_comb begin
        // b*v about 0.2 v, taken from the pre-spike next v
        bv_mu = BV_BW'((v_raw >>> 3) + (v_raw >>> 4) + (v_raw >>> 6) - V_POLY_BW'(u));
        // a about 0.005, includes the quarter step
        du    = DU_BW'((bv_mu >>> 8) + (bv_mu >>> 10));
        u_raw = STATE_BW'(du) + u;
        // Spike bumps recovery by d
        u_nxt = spiking ? u + STATE_BW'(U_SPIKE_STEP * (1 << MODEL_PREC)) : u_raw;
    end

    // Observation port
    assign state = '{v: v, u: u};

endmodule

/* source/spike_result.sv */
`timescale 1ns/10ps

module spike_result import neuron_pkg::*; #(
    parameter int NEURON_INDEX = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  nc_reset,
    input  logic                  nc_evaluate,
    input  logic                  nc_warmup,
    input  logic                  out_granted,
    input  logic                  spiking,
    input  cfg_write_t            cfg,
    output logic                  out_pending,
    output logic [OUT_BUS_BW-1:0] out_bus
);

    // Lengthening counter
    logic [STEP_BW-1:0] step_len;
    logic [STEP_BW-1:0] step_cntr;
    logic [STEP_BW-1:0] step_cntr_nxt;
    // Lengthened output level
    logic               out_level;
    logic               out_level_nxt;
    // Waiting for a grant since the last evaluate
    logic               pend;
    logic               upd_en;

    // Step length register, only this address is decoded here
    always_ff @(posedge clk) begin
        if (rst) begin
            step_len <= STEP_BW'(STEP_RESET);
        end else if (cfg.we && cfg.addr == CFG_ADDR_BW'(CFG_STEP_ADDR)) begin
            step_len <= STEP_BW'(cfg.data);
        end
    end

    // Counter and level
    // --------------------
    // Warmup evaluates leave the output alone
    assign upd_en = (nc_evaluate && !nc_warmup) || out_granted;

    always_comb begin
        // Set on a fresh spike, or when the count runs out without one
        if ((spiking && step_cntr == '0)
            || (!spiking && step_cntr == STEP_BW'(1))) begin
            out_level_nxt = 1'b1;
        end else if (out_granted) begin
            out_level_nxt = 1'b0;
        end else begin
            out_level_nxt = out_level;
        end

        // Spike reloads, otherwise count down to zero
        step_cntr_nxt = step_cntr;
        if (spiking) begin
            step_cntr_nxt = step_len;
        end else if (step_cntr != '0) begin
            step_cntr_nxt = step_cntr - STEP_BW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || nc_reset) begin
            out_level <= 1'b0;
            step_cntr <= '0;
        end else if (upd_en) begin
            out_level <= out_level_nxt;
            step_cntr <= step_cntr_nxt;
        end
    end

    // Output port
    // --------------------
    // Grant wins over a same-cycle evaluate
    always_ff @(posedge clk) begin
        if (rst || out_granted) begin
            pend <= 1'b0;
        end else if (nc_evaluate) begin
            pend <= 1'b1;
        end
    end

    assign out_pending = out_level && pend;
    // Bus reads zero unless this neuron holds the grant
    assign out_bus = (out_pending && out_granted) ? OUT_BUS_BW'(NEURON_INDEX) : '0;

endmodule

/* source/neuron_top.sv */
`timescale 1ns/10ps

module neuron_top import neuron_pkg::*; #(
    parameter int NEURON_INDEX = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    // Configuration writes
    input  cfg_write_t            cfg,
    // Incoming axon index
    input  axon_in_t              axon,
    // Network controller strobes
    input  logic                  nc_evaluate,
    input  logic                  nc_reset,
    input  logic                  nc_warmup,
    // Output port
    input  logic                  out_granted,
    output logic                  neur_output,
    output logic                  out_pending,
    output logic [OUT_BUS_BW-1:0] out_bus,
    // v and u for observation
    output neuron_state_t         state
);

    // Decode to execute
    logic signed [CURRENT_BW-1:0] syn_current;
    logic signed [CURRENT_BW-1:0] bias_current;

    synapse_decode synapse_decode_i (
        .clk          (clk),
        .rst          (rst),
        .nc_reset     (nc_reset),
        .nc_evaluate  (nc_evaluate),
        .cfg          (cfg),
        .axon         (axon),
        .syn_current  (syn_current),
        .bias_current (bias_current)
    );

    // Spike flag goes straight out as neur_output
    izh_execute izh_execute_i (
        .clk          (clk),
        .rst          (rst),
        .nc_reset     (nc_reset),
        .nc_evaluate  (nc_evaluate),
        .syn_current  (syn_current),
        .bias_current (bias_current),
        .spiking      (neur_output),
        .state        (state)
    );

    spike_result #(
        .NEURON_INDEX (NEURON_INDEX)
    ) spike_result_i (
        .clk          (clk),
        .rst          (rst),
        .nc_reset     (nc_reset),
        .nc_evaluate  (nc_evaluate),
        .nc_warmup    (nc_warmup),
        .out_granted  (out_granted),
        .spiking      (neur_output),
        .cfg          (cfg),
        .out_pending  (out_pending),
        .out_bus      (out_bus)
    );

endmodule

/* tests/neuron_sva.sv */
`timescale 1ns/10ps

module neuron_sva import neuron_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  nc_evaluate,
    input logic                  out_granted,
    input logic                  neur_output,
    input logic                  out_pending,
    input logic [OUT_BUS_BW-1:0] out_bus
);

    // Bus is zero unless this neuron is pending and granted
    bus_quiet_a: assert property (
        @(posedge clk) disable iff (rst)
        !(out_pending && out_granted) |-> out_bus == '0
    ) else $error("out_bus driven without pending and grant");

    // Spike flag only in an evaluate cycle
    spike_in_eval_a: assert property (
        @(posedge clk) disable iff (rst)
        neur_output |-> nc_evaluate
    ) else $error("neur_output high outside an evaluate cycle");

    // Grant clears the request
    grant_drops_a: assert property (
        @(posedge clk) disable iff (rst)
        out_granted |=> !out_pending
    ) else $error("out_pending still high after a grant");

    // Port idle right after reset
    reset_idle_a: assert property (
        @(posedge clk)
        rst |=> (!out_pending && out_bus == '0)
    ) else $error("output port active after reset");

endmodule

bind neuron_top neuron_sva neuron_sva_i (
    .clk         (clk),
    .rst         (rst),
    .nc_evaluate (nc_evaluate),
    .out_granted (out_granted),
    .neur_output (neur_output),
    .out_pending (out_pending),
    .out_bus     (out_bus)
);

/* tests/neuron_tb.sv */
`timescale 1ns/10ps

module neuron_tb import neuron_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int NEURON_ID   = 5;
    // Rough cycle count of all tests together
    localparam int TEST_CYCLES = 2200;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 500) * CLK_PERIOD;
    localparam longint FX_ONE  = longint'(1) << MODEL_PREC;
    localparam logic signed [STATE_BW-1:0] V_INIT = STATE_BW'(V_RESET * (1 << MODEL_PREC));
    localparam logic signed [STATE_BW-1:0] U_INIT = STATE_BW'(U_RESET * (1 << MODEL_PREC));

    typedef struct packed {
        logic                       spike;
        logic signed [STATE_BW-1:0] v;
        logic signed [STATE_BW-1:0] u;
    } step_out_t;

    // DUT ports
    logic                  clk;
    logic                  rst;
    cfg_write_t            cfg;
    axon_in_t              axon;
    logic                  nc_evaluate;
    logic                  nc_reset;
    logic                  nc_warmup;
    logic                  out_granted;
    logic                  neur_output;
    logic                  out_pending;
    logic [OUT_BUS_BW-1:0] out_bus;
    neuron_state_t         state;

    // Reference model of the neuron
    logic signed [STATE_BW-1:0] ref_v;
    logic signed [STATE_BW-1:0] ref_u;
    int ref_bias;
    int ref_syn;
    // Synaptic current seen by the neuron, two cycles behind the beats
    int syn_d1;
    int syn_d2;
    int tbl_index  [TABLE_ROWS];
    int tbl_weight [TABLE_ROWS];
    bit tbl_sign   [TABLE_ROWS];
    int ref_step_len;
    int ref_cnt;
    bit ref_lvl;
    bit ref_pend;
    bit checking;
    int spikes_seen;
    int grants_seen;

    neuron_top #(
        .NEURON_INDEX (NEURON_ID)
    ) neuron_top_i (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .axon        (axon),
        .nc_evaluate (nc_evaluate),
        .nc_reset    (nc_reset),
        .nc_warmup   (nc_warmup),
        .out_granted (out_granted),
        .neur_output (neur_output),
        .out_pending (out_pending),
        .out_bus     (out_bus),
        .state       (state)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference arithmetic
    // --------------------
    // Keep the low bw bits as a signed value
    function automatic longint wrap_bits(input longint x, input int bw);
        longint m;
        m = x & ((longint'(1) << bw) - 1);
        if (m >= (longint'(1) << (bw - 1))) begin
            m = m - (longint'(1) << bw);
        end
        return m;
    endfunction

    // One quarter-step of the fixed-point Izhikevich model
    function automatic step_out_t izh_step(input longint v, input longint u, input longint cur);
        longint    vh;
        longint    sq;
        longint    sqk;
        longint    x5;
        longint    drv;
        longint    dv;
        longint    vr;
        longint    bvu;
        longint    du;
        step_out_t res;
        // Half the fraction dropped and the square kept to 25 bits
        vh  = v >>> (MODEL_PREC / 2);
        sq  = wrap_bits(vh * vh, 25);
        // About 0.04 v^2
        sqk = wrap_bits((sq >>> 5) + (sq >>> 7) + (sq >>> 10), V_POLY_BW);
        x5  = wrap_bits(v * 5, V_POLY_BW);
        // 140 plus current moved from weight to model fraction
        drv = longint'(BIAS_140) * FX_ONE + cur * (longint'(1) << (MODEL_PREC - WEIGHT_PREC));
        dv  = wrap_bits(sqk + x5 - u + drv, DV_BW);
        vr  = wrap_bits(v + wrap_bits(dv >>> 2, V_POLY_BW), V_POLY_BW);
        res.spike = (vr >>> MODEL_PREC) > longint'(V_SPIKE);
        // Recovery from the pre-spike next v
        bvu = wrap_bits((vr >>> 3) + (vr >>> 4) + (vr >>> 6) - u, BV_BW);
        du  = wrap_bits((bvu >>> 8) + (bvu >>> 10), DU_BW);
        if (res.spike) begin
            res.v = STATE_BW'(longint'(V_AFTER_SPIKE) * FX_ONE);
            res.u = STATE_BW'(u + longint'(U_SPIKE_STEP) * FX_ONE);
        end else begin
            res.v = STATE_BW'(vr);
            res.u = STATE_BW'(u + du);
        end
        return res;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // Compare process
    // --------------------
    // Checks outputs mid-cycle and steps the model over the coming edge
    always @(negedge clk) begin
        step_out_t             nxt;
        logic [OUT_BUS_BW-1:0] bus_exp;
        bit                    spk;
        bit                    lvl_nxt;
        nxt     = izh_step(longint'(ref_v), longint'(ref_u), longint'(ref_bias + syn_d2));
        spk     = nc_evaluate && nxt.spike;
        bus_exp = (ref_lvl && ref_pend && out_granted) ? OUT_BUS_BW'(NEURON_ID) : '0;
        if (checking) begin
            assert (state.v == ref_v && state.u == ref_u)
            else stop_run($sformatf("** Error at %0t: state v=%0d u=%0d, expected v=%0d u=%0d",
                                    $time, state.v, state.u, ref_v, ref_u));
            assert (neur_output == spk)
            else stop_run($sformatf("** Error at %0t: neur_output=%0b, expected %0b",
                                    $time, neur_output, spk));
            assert (out_pending == (ref_lvl && ref_pend))
            else stop_run($sformatf("** Error at %0t: out_pending=%0b, expected %0b",
                                    $time, out_pending, ref_lvl && ref_pend));
            assert (out_bus == bus_exp)
            else stop_run($sformatf("** Error at %0t: out_bus=%0d, expected %0d",
                                    $time, out_bus, bus_exp));
        end
        if (rst) begin
            ref_step_len = STEP_RESET;
            ref_pend     = 1'b0;
        end else if (out_granted) begin
            ref_pend = 1'b0;
        end else if (nc_evaluate) begin
            ref_pend = 1'b1;
        end
        if (rst || nc_reset) begin
            ref_v   = V_INIT;
            ref_u   = U_INIT;
            ref_cnt = 0;
            ref_lvl = 1'b0;
            syn_d1  = 0;
            syn_d2  = 0;
        end else begin
            // One stage for the axon register, one for the accumulator
            syn_d2 = syn_d1;
            syn_d1 = ref_syn;
            if (nc_evaluate) begin
                ref_v = nxt.v;
                ref_u = nxt.u;
                if (nxt.spike) begin
                    spikes_seen++;
                end
            end
            // Lengthening counter skips warmup evaluates
            if ((nc_evaluate && !nc_warmup) || out_granted) begin
                lvl_nxt = ref_lvl;
                if ((spk && ref_cnt == 0) || (!spk && ref_cnt == 1)) begin
                    lvl_nxt = 1'b1;
                end else if (out_granted) begin
                    lvl_nxt = 1'b0;
                end
                if (spk) begin
                    ref_cnt = ref_step_len;
                end else if (ref_cnt != 0) begin
                    ref_cnt--;
                end
                ref_lvl = lvl_nxt;
            end
        end
    end

    // Stimulus tasks
    // --------------------
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic write_cfg(input int addr, input int data);
        cfg.we   = 1'b1;
        cfg.addr = CFG_ADDR_BW'(addr);
        cfg.data = CFG_DATA_BW'(data);
        tick();
        cfg = '0;
    endtask

    task automatic set_bias(input int bias);
        write_cfg(CFG_BIAS_ADDR, bias);
        ref_bias = bias;
    endtask

    task automatic set_step(input int len);
        write_cfg(CFG_STEP_ADDR, len);
        ref_step_len = len;
    endtask

    task automatic set_row(input int row, input int index, input int weight);
        write_cfg(CFG_TABLE_BASE + 2 * row, index);
        write_cfg(CFG_TABLE_BASE + 2 * row + 1, weight);
        tbl_index[row]  = index;
        tbl_weight[row] = weight;
    endtask

    // Every row matching the beat adds or subtracts its weight and toggles
    task automatic send_axon(input int index);
        axon.vld   = 1'b1;
        axon.index = INDEX_BW'(index);
        for (int r = 0; r < TABLE_ROWS; r++) begin
            if (tbl_index[r] == index) begin
                if (tbl_sign[r]) begin
                    ref_syn = int'(wrap_bits(longint'(ref_syn - tbl_weight[r]), CURRENT_BW));
                end else begin
                    ref_syn = int'(wrap_bits(longint'(ref_syn + tbl_weight[r]), CURRENT_BW));
                end
                tbl_sign[r] = !tbl_sign[r];
            end
        end
        tick();
        axon = '0;
    endtask

    task automatic evaluate(input bit warm);
        nc_evaluate = 1'b1;
        nc_warmup   = warm;
        tick();
        nc_evaluate = 1'b0;
        nc_warmup   = 1'b0;
    endtask

    task automatic grant();
        if (ref_lvl && ref_pend) begin
            grants_seen++;
        end
        out_granted = 1'b1;
        tick();
        out_granted = 1'b0;
    endtask

    task automatic pulse_reset();
        nc_reset = 1'b1;
        tick();
        nc_reset = 1'b0;
        ref_syn  = 0;
        for (int r = 0; r < TABLE_ROWS; r++) begin
            tbl_sign[r] = 1'b0;
        end
    endtask

    // A few beats with repeats, at times followed by one idle cycle
    task automatic axon_burst(input int max_beats);
        int beats;
        int idx;
        beats = int'($urandom % max_beats);
        idx   = int'($urandom % 10);
        for (int b = 0; b < beats; b++) begin
            if ($urandom % 3 == 0) begin
                idx = int'($urandom % 10);
            end
            send_axon(idx);
        end
        // Without the idle cycle the last beat is still on its way to the current
        if ($urandom % 2 == 0) begin
            tick();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_run("Timeout: the tests did not finish in the expected time");
    end

    // Main sequence
    // --------------------
    initial begin
        void'($urandom(32'hb18f63ff));
        rst          = 1'b1;
        cfg          = '0;
        axon         = '0;
        nc_evaluate  = 1'b0;
        nc_reset     = 1'b0;
        nc_warmup    = 1'b0;
        out_granted  = 1'b0;
        checking     = 1'b0;
        ref_bias     = 0;
        ref_syn      = 0;
        syn_d1       = 0;
        syn_d2       = 0;
        ref_step_len = STEP_RESET;
        spikes_seen  = 0;
        grants_seen  = 0;
        for (int r = 0; r < TABLE_ROWS; r++) begin
            tbl_index[r]  = 0;
            tbl_weight[r] = 0;
            tbl_sign[r]   = 1'b0;
        end
        repeat (16) tick();
        rst = 1'b0;

        // Reset state
        assert (state.v == V_INIT && state.u == U_INIT)
        else stop_run($sformatf("** Error at %0t: reset state v=%0d u=%0d",
                                $time, state.v, state.u));
        assert (!neur_output && !out_pending && out_bus == '0)
        else stop_run($sformatf("** Error at %0t: outputs active after reset", $time));
        checking = 1'b1;

        // Bias only and long enough for repeated spikes
        set_bias(int'($urandom % 60) + 40);
        repeat (200) evaluate(1'b0);
        assert (spikes_seen > 0)
        else stop_run("The bias run produced no spike");

        // Random table with indices 0 to 7 so rows share indices
        for (int r = 0; r < TABLE_ROWS; r++) begin
            set_row(r, int'($urandom % 8), int'($urandom % 25) - 12);
        end
        set_bias(int'($urandom % 40));
        for (int s = 0; s < 150; s++) begin
            axon_burst(4);
            evaluate(1'b0);
            if (out_pending) begin
                grant();
            end
        end

        // Output lengthening with two step lengths and some warmup evaluates
        set_bias(int'($urandom % 60) + 40);
        for (int p = 0; p < 2; p++) begin
            set_step(p == 0 ? 5 : 12);
            for (int s = 0; s < 120; s++) begin
                evaluate(($urandom % 4) == 0);
                tick();
                if (out_pending || ($urandom % 5) == 0) begin
                    grant();
                end
            end
        end
        assert (grants_seen > 0)
        else stop_run("No grant reached a pending output");

        // Controller reset keeps bias and table
        repeat (10) evaluate(1'b0);
        pulse_reset();
        assert (state.v == V_INIT && state.u == U_INIT)
        else stop_run($sformatf("** Error at %0t: nc_reset state v=%0d u=%0d",
                                $time, state.v, state.u));
        for (int s = 0; s < 40; s++) begin
            axon_burst(3);
            evaluate(1'b0);
        end

        repeat (4) tick();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* all.f */
source/neuron_pkg.sv
source/synapse_decode.sv
source/izh_execute.sv
source/spike_result.sv
source/neuron_top.sv
tests/neuron_sva.sv
tests/neuron_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the neuron testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module neuron_tb -f all.f -o neuron_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/neuron_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
